/* isa_pkg.sv */
// Instruction set types
// Opcode, branch condition and pipeline select encodings plus the decoded instruction

`default_nettype none

package isa_pkg;

	typedef enum logic [4:0] {
		OP_OR,
		OP_AND,
		OP_UMINUS,
		OP_XOR,
		OP_IADD,
		OP_ISUB,
		OP_LSR,
		OP_ASR,
		OP_LSL,
		OP_CLZ,
		OP_CTZ,
		OP_COPY,
		OP_EQUAL,
		OP_NEQUAL,
		OP_SIGTR,
		OP_SIGTE,
		OP_SILT,
		OP_SILTE,
		OP_UIGTR,
		OP_UIGTE,
		OP_UILT,
		OP_UILTE,
		OP_SEXT8,
		OP_SEXT16,
		OP_SHUFFLE,
		OP_GETLANE
	} alu_op_t;

	// Conditions are tested on lane 0 of operand1
	typedef enum logic [2:0] {
		BRANCH_ZERO,
		BRANCH_NOT_ZERO,
		BRANCH_ALL,
		BRANCH_NOT_ALL,
		BRANCH_ALWAYS,
		BRANCH_CALL_OFFSET,
		BRANCH_CALL_REGISTER
	} branch_type_t;

	typedef enum logic [1:0] {
		PIPE_MEM,
		PIPE_SCYCLE_ARITH,
		PIPE_MCYCLE_ARITH
	} pipe_sel_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic is_branch;
		branch_type_t branch_type;
		pipe_sel_t pipeline_sel;
		logic [31:0] pc;
		logic [31:0] immediate_value;
	} decoded_instruction_t;

endpackage

`default_nettype wire

/* issue_queue.sv */
// Issue queue
// Circular FIFO of issue bundles, popped on grant, one credit back to the sender per pop

`include "vec_params.svh"
`default_nettype none

module issue_queue
	import pipe_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic in_valid,
	input wire issue_bundle_t in_bundle,
	input wire logic issue_grant,
	output logic of_valid,
	output issue_bundle_t of_bundle,
	output logic in_credit
);
	localparam int PTR_W = $clog2(`ISSUE_DEPTH);

	issue_bundle_t entries[`ISSUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [`IN_CREDIT_WIDTH-1:0] occupancy;
	logic empty;
	logic pop;

	assign empty = occupancy == '0;
	assign pop = !empty && issue_grant;

	// Head is presented in the same cycle it is popped
	assign of_valid = pop;
	assign of_bundle = entries[rd_ptr];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occupancy <= '0;
			in_credit <= 1'b0;
		end
		else
		begin
			// Sender holds a credit for every push, so no full check here
			if (in_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({in_valid, pop})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
			in_credit <= pop;
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_valid)
			entries[wr_ptr] <= in_bundle;
	end

endmodule

`default_nettype wire

/* pipe_pkg.sv */
// Pipeline datapath types
// Scalar and vector words, thread index and the bundles passed between stages

`include "vec_params.svh"
`default_nettype none

package pipe_pkg;
	import isa_pkg::*;

	typedef logic [31:0] scalar_t;
	typedef scalar_t [`VECTOR_LANES-1:0] vector_t;
	typedef logic [$clog2(`THREADS)-1:0] thread_idx_t;

	// Decoded instruction with its operands already fetched
	typedef struct packed {
		decoded_instruction_t instruction;
		vector_t operand1;
		vector_t operand2;
		logic [`VECTOR_LANES-1:0] mask;
		thread_idx_t thread;
	} issue_bundle_t;

	typedef struct packed {
		decoded_instruction_t instruction;
		vector_t result;
		logic [`VECTOR_LANES-1:0] mask;
		thread_idx_t thread;
	} exec_bundle_t;

	// Carried on the core output port
	typedef struct packed {
		scalar_t pc;
		thread_idx_t thread;
		logic [`VECTOR_LANES-1:0] mask;
		vector_t result;
	} result_bundle_t;

endpackage

`default_nettype wire

/* single_cycle_execute_stage.sv */
// Single-cycle execute stage
// Per-lane integer ALU and branch resolution, results registered toward writeback

`include "vec_params.svh"
`default_nettype none

module single_cycle_execute_stage
	import isa_pkg::*, pipe_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic of_valid,
	input wire issue_bundle_t of_bundle,
	input wire logic wb_rollback_en,
	input wire thread_idx_t wb_rollback_thread,
	output logic sx_valid,
	output exec_bundle_t sx_bundle,
	output logic sx_rollback_en,
	output scalar_t sx_rollback_pc
);
	localparam int LANE_IDX_W = $clog2(`VECTOR_LANES);

	decoded_instruction_t instr;
	vector_t lane_results;
	scalar_t branch_value;
	logic instr_valid;
	logic branch_taken;

	assign instr = of_bundle.instruction;
	assign branch_value = of_bundle.operand1[0];

	genvar lane;
	generate
		for (lane = 0; lane < `VECTOR_LANES; lane++)
		begin : lane_alu_gen
			scalar_t op1;
			scalar_t op2;
			scalar_t difference;
			scalar_t rshift;
			scalar_t lane_result;
			logic borrow;
			logic overflow;
			logic zero;
			logic signed_gtr;
			logic shift_in_sign;
			logic [5:0] lz;
			logic [5:0] tz;

			assign op1 = of_bundle.operand1[lane];
			assign op2 = of_bundle.operand2[lane];

			// Compares all come from one subtract
			assign {borrow, difference} = {1'b0, op1} - {1'b0, op2};
			assign overflow = op2[31] == difference[31] && op1[31] != op2[31];
			assign zero = difference == 32'd0;
			assign signed_gtr = overflow == difference[31];

			assign shift_in_sign = instr.alu_op == OP_ASR ? op1[31] : 1'b0;
			assign rshift = scalar_t'({{32{shift_in_sign}}, op1} >> op2[4:0]);

			// Highest set bit wins
			always_comb
			begin
				lz = 6'd32;
				for (int i = 0; i < 32; i++)
				begin
					if (op2[i])
						lz = 6'(31 - i);
				end
			end

			// Lowest set bit wins
			always_comb
			begin
				tz = 6'd32;
				for (int i = 31; i >= 0; i--)
				begin
					if (op2[i])
						tz = 6'(i);
				end
			end

			always_comb
			begin
				case (instr.alu_op)
					OP_OR: lane_result = op1 | op2;
					OP_AND: lane_result = op1 & op2;
					OP_XOR: lane_result = op1 ^ op2;
					OP_UMINUS: lane_result = -op2;
					OP_IADD: lane_result = op1 + op2;
					OP_ISUB: lane_result = difference;
					OP_LSR,
					OP_ASR: lane_result = rshift;
					OP_LSL: lane_result = op1 << op2[4:0];
					OP_CLZ: lane_result = {26'd0, lz};
					OP_CTZ: lane_result = {26'd0, tz};
					OP_COPY: lane_result = op2;
					OP_EQUAL: lane_result = {31'd0, zero};
					OP_NEQUAL: lane_result = {31'd0, !zero};
					OP_SIGTR: lane_result = {31'd0, signed_gtr && !zero};
					OP_SIGTE: lane_result = {31'd0, signed_gtr || zero};
					OP_SILT: lane_result = {31'd0, !signed_gtr && !zero};
					OP_SILTE: lane_result = {31'd0, !signed_gtr || zero};
					OP_UIGTR: lane_result = {31'd0, !borrow && !zero};
					OP_UIGTE: lane_result = {31'd0, !borrow || zero};
					OP_UILT: lane_result = {31'd0, borrow && !zero};
					OP_UILTE: lane_result = {31'd0, borrow || zero};
					OP_SEXT8: lane_result = {{24{op2[7]}}, op2[7:0]};
					OP_SEXT16: lane_result = {{16{op2[15]}}, op2[15:0]};
					OP_SHUFFLE,
					OP_GETLANE: lane_result = of_bundle.operand1[~op2[LANE_IDX_W-1:0]];
					default: lane_result = 32'd0;
				endcase
			end

			assign lane_results[lane] = lane_result;
		end
	endgenerate

	// Drop other pipes and anything of a thread being rolled back this cycle
	assign instr_valid = of_valid && instr.pipeline_sel == PIPE_SCYCLE_ARITH
		&& !(wb_rollback_en && wb_rollback_thread == of_bundle.thread);

	always_comb
	begin
		case (instr.branch_type)
			BRANCH_ZERO: branch_taken = branch_value == 32'd0;
			BRANCH_NOT_ZERO: branch_taken = branch_value != 32'd0;
			BRANCH_ALL: branch_taken = branch_value[15:0] == 16'hffff;
			BRANCH_NOT_ALL: branch_taken = branch_value[15:0] != 16'hffff;
			BRANCH_ALWAYS,
			BRANCH_CALL_OFFSET,
			BRANCH_CALL_REGISTER: branch_taken = 1'b1;
			default: branch_taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			sx_valid <= 1'b0;
			sx_rollback_en <= 1'b0;
		end
		else
		begin
			sx_valid <= instr_valid;
			sx_rollback_en <= instr_valid && instr.is_branch && branch_taken;
		end
	end

	always_ff @(posedge clk)
	begin
		sx_bundle.instruction <= instr;
		sx_bundle.result <= lane_results;
		sx_bundle.mask <= of_bundle.mask;
		sx_bundle.thread <= of_bundle.thread;
		if (instr.branch_type == BRANCH_CALL_REGISTER)
			sx_rollback_pc <= branch_value;
		else
			sx_rollback_pc <= instr.pc + 32'd4 + instr.immediate_value;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
isa_pkg.sv
pipe_pkg.sv
issue_queue.sv
single_cycle_execute_stage.sv
writeback_stage.sv
vector_core_top.sv
tb_vector_core.sv

/* tb_vector_core.sv */
// Vector core testbench
// Directed tests with a reference model, a credit-tracking sender and a stalling consumer

`include "vec_params.svh"
`default_nettype none

module tb_vector_core
	import isa_pkg::*, pipe_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		thread_idx_t thread;
		scalar_t pc;
	} rollback_t;

	localparam int NUM_OPS = int'(OP_GETLANE) + 1;
	localparam int NUM_BRANCHES = int'(BRANCH_CALL_REGISTER) + 1;
	localparam int BP_COUNT = 32;
	localparam int TOTAL_INSTRS = 1 + NUM_OPS * `THREADS + NUM_BRANCHES * 2 + 4 + 7 + BP_COUNT;
	localparam int DRAIN_LIMIT = 200;
	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_NS = (TOTAL_INSTRS * 20 + NUM_TESTS * (DRAIN_LIMIT + 10) + 20) * 10;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic in_valid = 1'b0;
	issue_bundle_t in_bundle = '0;
	logic out_credit = 1'b0;
	logic in_credit;
	logic out_valid;
	result_bundle_t out_bundle;
	logic rollback_en;
	thread_idx_t rollback_thread;
	scalar_t rollback_pc;

	result_bundle_t exp_q[$];
	rollback_t rb_q[$];
	string test_name = "none";
	scalar_t next_pc = 32'h1000;
	int sent = 0;
	int returned = 0;
	int pending = 0;
	int core_credits = `OUT_CREDITS;
	int error_count = 0;
	int check_count = 0;
	bit stall_mode = 1'b0;

	vector_core_top vector_core_top_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_bundle(in_bundle),
		.out_credit(out_credit),
		.in_credit(in_credit),
		.out_valid(out_valid),
		.out_bundle(out_bundle),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.rollback_pc(rollback_pc)
	);

	always #5 clk = ~clk;

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		check_count++;
		if (expected !== actual)
		begin
			error_count++;
			$display("** Error [%s]: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic report_failure(input string msg);
		error_count++;
		$display("Failure [%s]: %s", test_name, msg);
	endtask

	function automatic scalar_t expected_lane(alu_op_t op, scalar_t a, scalar_t b, vector_t op1);
		scalar_t r;
		int count;
		r = '0;
		count = 0;
		case (op)
			OP_OR: r = a | b;
			OP_AND: r = a & b;
			OP_XOR: r = a ^ b;
			OP_UMINUS: r = 32'd0 - b;
			OP_IADD: r = a + b;
			OP_ISUB: r = a - b;
			OP_LSR: r = a >> b[4:0];
			OP_ASR: r = $signed(a) >>> b[4:0];
			OP_LSL: r = a << b[4:0];
			OP_CLZ:
			begin
				while (count < 32 && !b[31 - count])
					count++;
				r = scalar_t'(count);
			end
			OP_CTZ:
			begin
				while (count < 32 && !b[count])
					count++;
				r = scalar_t'(count);
			end
			OP_COPY: r = b;
			OP_EQUAL: r = {31'd0, a == b};
			OP_NEQUAL: r = {31'd0, a != b};
			OP_SIGTR: r = {31'd0, $signed(a) > $signed(b)};
			OP_SIGTE: r = {31'd0, $signed(a) >= $signed(b)};
			OP_SILT: r = {31'd0, $signed(a) < $signed(b)};
			OP_SILTE: r = {31'd0, $signed(a) <= $signed(b)};
			OP_UIGTR: r = {31'd0, a > b};
			OP_UIGTE: r = {31'd0, a >= b};
			OP_UILT: r = {31'd0, a < b};
			OP_UILTE: r = {31'd0, a <= b};
			OP_SEXT8: r = {{24{b[7]}}, b[7:0]};
			OP_SEXT16: r = {{16{b[15]}}, b[15:0]};
			// Lanes are numbered from the top of the vector
			OP_SHUFFLE,
			OP_GETLANE: r = op1[`VECTOR_LANES - 1 - (b % `VECTOR_LANES)];
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic bit branch_holds(branch_type_t bt, scalar_t v);
		case (bt)
			BRANCH_ZERO: return v == 32'd0;
			BRANCH_NOT_ZERO: return v != 32'd0;
			BRANCH_ALL: return v[15:0] == 16'hffff;
			BRANCH_NOT_ALL: return v[15:0] != 16'hffff;
			default: return 1'b1;
		endcase
	endfunction

	function automatic scalar_t branch_target(issue_bundle_t b);
		if (b.instruction.branch_type == BRANCH_CALL_REGISTER)
			return b.operand1[0];
		return b.instruction.pc + 32'd4 + b.instruction.immediate_value;
	endfunction

	function automatic issue_bundle_t make_bundle(alu_op_t op, thread_idx_t thread,
		pipe_sel_t pipe);
		issue_bundle_t b;
		scalar_t r;
		b = '0;
		b.instruction.alu_op = op;
		b.instruction.pipeline_sel = pipe;
		b.instruction.immediate_value = $urandom;
		for (int i = 0; i < `VECTOR_LANES; i++)
		begin
			b.operand1[i] = $urandom;
			b.operand2[i] = $urandom;
		end
		r = $urandom;
		b.mask = r[`VECTOR_LANES-1:0];
		b.thread = thread;
		return b;
	endfunction

	// Waits for a sender credit, records the expected response and drives one cycle
	task automatic send(input issue_bundle_t b, input bit squashed);
		issue_bundle_t item;
		result_bundle_t expected;
		rollback_t rb;
		item = b;
		item.instruction.pc = next_pc;
		next_pc = next_pc + 32'd4;
		while (sent - returned >= `ISSUE_DEPTH)
			@(negedge clk);
		if (item.instruction.pipeline_sel == PIPE_SCYCLE_ARITH && !squashed)
		begin
			expected.pc = item.instruction.pc;
			expected.thread = item.thread;
			expected.mask = item.mask;
			for (int i = 0; i < `VECTOR_LANES; i++)
				expected.result[i] = expected_lane(item.instruction.alu_op, item.operand1[i],
					item.operand2[i], item.operand1);
			exp_q.push_back(expected);
			if (item.instruction.is_branch
				&& branch_holds(item.instruction.branch_type, item.operand1[0]))
			begin
				rb.thread = item.thread;
				rb.pc = branch_target(item);
				rb_q.push_back(rb);
			end
		end
		in_valid = 1'b1;
		in_bundle = item;
		sent++;
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic drain();
		int cycles;
		cycles = 0;
		while ((exp_q.size() != 0 || rb_q.size() != 0 || returned != sent || pending != 0)
			&& cycles < DRAIN_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() != 0)
			report_failure($sformatf("%0d results never arrived", exp_q.size()));
		if (rb_q.size() != 0)
			report_failure($sformatf("%0d rollbacks never appeared", rb_q.size()));
		if (returned != sent)
			report_failure($sformatf("in_credit returned %0d of %0d", returned, sent));
		exp_q.delete();
		rb_q.delete();
		// Idle time lets any stray result show up
		repeat (4) @(negedge clk);
	endtask

	task automatic take_result();
		result_bundle_t expected;
		if (exp_q.size() == 0)
			report_failure($sformatf("unexpected result with pc %0h", out_bundle.pc));
		else
		begin
			expected = exp_q.pop_front();
			check_value({test_name, " pc"}, expected.pc, out_bundle.pc);
			check_value({test_name, " thread"}, expected.thread, out_bundle.thread);
			check_value({test_name, " mask"}, expected.mask, out_bundle.mask);
			check_value({test_name, " result"}, expected.result, out_bundle.result);
		end
		if (core_credits == 0)
			report_failure("result sent without a consumer credit");
		else
			core_credits--;
		pending++;
	endtask

	task automatic take_rollback();
		rollback_t expected;
		if (rb_q.size() == 0)
			report_failure($sformatf("rollback with no taken branch, pc %0h", rollback_pc));
		else
		begin
			expected = rb_q.pop_front();
			check_value({test_name, " rollback_thread"}, expected.thread, rollback_thread);
			check_value({test_name, " rollback_pc"}, expected.pc, rollback_pc);
		end
	endtask

	// Output monitor and consumer, sampled mid-cycle where outputs are stable
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (out_valid)
				take_result();
			if (rollback_en)
				take_rollback();
			if (in_credit)
			begin
				returned++;
				if (returned > sent)
					report_failure("sender credits exceed the issue queue depth");
			end
			if (pending > 0 && (!stall_mode || $urandom_range(3) == 0))
			begin
				out_credit = 1'b1;
				pending--;
				core_credits++;
			end
			else
				out_credit = 1'b0;
		end
	end

	task automatic reset_values();
		int cycles;
		test_name = "reset";
		repeat (5)
		begin
			@(negedge clk);
			check_value("reset out_valid", 0, out_valid);
			check_value("reset in_credit", 0, in_credit);
			check_value("reset rollback_en", 0, rollback_en);
			check_value("reset issue_grant", 0, vector_core_top_i.issue_grant);
		end
		reset = 1'b0;
		send(make_bundle(OP_IADD, 0, PIPE_SCYCLE_ARITH), 1'b0);
		// Edge N samples in_valid, out_valid follows edge N+2
		cycles = 0;
		while (!out_valid && cycles < 8)
		begin
			@(negedge clk);
			cycles++;
		end
		check_value("reset latency", 2, cycles);
		drain();
	endtask

	task automatic alu_ops();
		issue_bundle_t b;
		test_name = "alu";
		for (int op = 0; op < NUM_OPS; op++)
			for (int t = 0; t < `THREADS; t++)
			begin
				b = make_bundle(alu_op_t'(op), thread_idx_t'(t), PIPE_SCYCLE_ARITH);
				// Equal operands reach the zero and equality cases
				if (t == `THREADS - 1)
					b.operand2 = b.operand1;
				send(b, 1'b0);
			end
		drain();
	endtask

	task automatic branch_types();
		issue_bundle_t b;
		int n;
		test_name = "branch";
		n = 0;
		for (int bt = 0; bt < NUM_BRANCHES; bt++)
			for (int want = 0; want < 2; want++)
			begin
				// Rotating threads keep a taken branch from squashing its neighbour
				b = make_bundle(alu_op_t'($urandom_range(NUM_OPS - 1)), thread_idx_t'(n % `THREADS),
					PIPE_SCYCLE_ARITH);
				b.instruction.is_branch = 1'b1;
				b.instruction.branch_type = branch_type_t'(bt);
				case (branch_type_t'(bt))
					BRANCH_ZERO: b.operand1[0] = want ? 32'd0 : ($urandom | 32'd1);
					BRANCH_NOT_ZERO: b.operand1[0] = want ? ($urandom | 32'd1) : 32'd0;
					BRANCH_ALL: b.operand1[0] = want ? ($urandom | 32'hffff) : ($urandom & ~32'd1);
					BRANCH_NOT_ALL: b.operand1[0] = want ? ($urandom & ~32'd1) : ($urandom | 32'hffff);
					default: b.operand1[0] = $urandom;
				endcase
				send(b, 1'b0);
				n++;
			end
		drain();
	endtask

	task automatic squash_after_branch();
		issue_bundle_t b;
		test_name = "squash";
		b = make_bundle(OP_COPY, 1, PIPE_SCYCLE_ARITH);
		b.instruction.is_branch = 1'b1;
		b.instruction.branch_type = BRANCH_ALWAYS;
		// Other thread pops while the rollback is visible and must survive
		send(b, 1'b0);
		send(make_bundle(OP_XOR, 2, PIPE_SCYCLE_ARITH), 1'b0);
		b = make_bundle(OP_COPY, 1, PIPE_SCYCLE_ARITH);
		b.instruction.is_branch = 1'b1;
		b.instruction.branch_type = BRANCH_ALWAYS;
		send(b, 1'b0);
		send(make_bundle(OP_IADD, 1, PIPE_SCYCLE_ARITH), 1'b1);
		drain();
	endtask

	task automatic pipe_select();
		issue_bundle_t b;
		test_name = "pipe_select";
		for (int i = 0; i < 6; i++)
			send(make_bundle(OP_IADD, thread_idx_t'(i % `THREADS),
				pipe_sel_t'(i % 3)), 1'b0);
		// A taken branch bound for another pipe must not roll back
		b = make_bundle(OP_OR, 3, PIPE_MEM);
		b.instruction.is_branch = 1'b1;
		b.instruction.branch_type = BRANCH_ALWAYS;
		send(b, 1'b0);
		drain();
	endtask

	task automatic back_pressure();
		test_name = "back_pressure";
		stall_mode = 1'b1;
		for (int i = 0; i < BP_COUNT; i++)
			send(make_bundle(alu_op_t'($urandom_range(NUM_OPS - 1)),
				thread_idx_t'($urandom_range(`THREADS - 1)), PIPE_SCYCLE_ARITH), 1'b0);
		drain();
		stall_mode = 1'b0;
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h12d5ba19));
		reset_values();
		alu_ops();
		branch_types();
		squash_after_branch();
		pipe_select();
		back_pressure();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vec_params.svh */
// Vector core sizing macros
// Lane and thread counts, queue depth and credit counter widths

`ifndef VEC_PARAMS_SVH
`define VEC_PARAMS_SVH
`default_nettype none

`define VECTOR_LANES 4
`define THREADS 4
`define ISSUE_DEPTH 4
`define OUT_CREDITS 4
// Counters must hold ISSUE_DEPTH and OUT_CREDITS
`define IN_CREDIT_WIDTH 3
`define OUT_CREDIT_WIDTH 3

`default_nettype wire
`endif

/* vector_core_top.sv */
// Vector core pipeline slice
// Issue queue, single-cycle execute and writeback between credit-based ports

`default_nettype none

module vector_core_top
	import pipe_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic in_valid,
	input wire issue_bundle_t in_bundle,
	input wire logic out_credit,
	output logic in_credit,
	output logic out_valid,
	output result_bundle_t out_bundle,
	output logic rollback_en,
	output thread_idx_t rollback_thread,
	output scalar_t rollback_pc
);
	logic issue_grant;
	logic of_valid;
	issue_bundle_t of_bundle;
	logic sx_valid;
	exec_bundle_t sx_bundle;
	logic sx_rollback_en;
	scalar_t sx_rollback_pc;

	issue_queue issue_queue_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_bundle(in_bundle),
		.issue_grant(issue_grant),
		.of_valid(of_valid),
		.of_bundle(of_bundle),
		.in_credit(in_credit)
	);

	// Rollback from writeback squashes same-thread work entering execute
	single_cycle_execute_stage single_cycle_execute_stage_i (
		.clk(clk),
		.reset(reset),
		.of_valid(of_valid),
		.of_bundle(of_bundle),
		.wb_rollback_en(rollback_en),
		.wb_rollback_thread(rollback_thread),
		.sx_valid(sx_valid),
		.sx_bundle(sx_bundle),
		.sx_rollback_en(sx_rollback_en),
		.sx_rollback_pc(sx_rollback_pc)
	);

	writeback_stage writeback_stage_i (
		.clk(clk),
		.reset(reset),
		.sx_valid(sx_valid),
		.sx_bundle(sx_bundle),
		.sx_rollback_en(sx_rollback_en),
		.sx_rollback_pc(sx_rollback_pc),
		.of_valid(of_valid),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.out_bundle(out_bundle),
		.wb_rollback_en(rollback_en),
		.wb_rollback_thread(rollback_thread),
		.wb_rollback_pc(rollback_pc),
		.issue_grant(issue_grant)
	);

endmodule

`default_nettype wire

/* writeback_stage.sv */
// Writeback stage
// Registers results for output, broadcasts rollbacks and gates issue on consumer credits

`include "vec_params.svh"
`default_nettype none

module writeback_stage
	import pipe_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic sx_valid,
	input wire exec_bundle_t sx_bundle,
	input wire logic sx_rollback_en,
	input wire scalar_t sx_rollback_pc,
	input wire logic of_valid,
	input wire logic out_credit,
	output logic out_valid,
	output result_bundle_t out_bundle,
	output logic wb_rollback_en,
	output thread_idx_t wb_rollback_thread,
	output scalar_t wb_rollback_pc,
	output logic issue_grant
);
	localparam int CW = `OUT_CREDIT_WIDTH;

	logic [CW-1:0] credit_count;
	logic [CW-1:0] in_flight;
	logic [1:0] pop_history;
	logic grant_enable;

	assign wb_rollback_en = sx_rollback_en;
	assign wb_rollback_thread = sx_bundle.thread;
	assign wb_rollback_pc = sx_rollback_pc;

	// Pops of the last two cycles have not reached out_valid yet
	assign in_flight = CW'(pop_history[0]) + CW'(pop_history[1]);
	assign issue_grant = grant_enable && credit_count > in_flight;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			credit_count <= CW'(`OUT_CREDITS);
			pop_history <= 2'b00;
			grant_enable <= 1'b0;
		end
		else
		begin
			out_valid <= sx_valid;
			credit_count <= credit_count + CW'(out_credit) - CW'(out_valid);
			pop_history <= {pop_history[0], of_valid};
			grant_enable <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (sx_valid)
		begin
			out_bundle.pc <= sx_bundle.instruction.pc;
			out_bundle.thread <= sx_bundle.thread;
			out_bundle.mask <= sx_bundle.mask;
			out_bundle.result <= sx_bundle.result;
		end
	end

endmodule

`default_nettype wire
